//--- sources.f
+incdir+include
logic/router_pkg.sv
logic/ingress_decode.sv
logic/route_execute.sv
logic/egress_result.sv
logic/p4_router.sv
sim/p4_router_props.sv
sim/p4_router_tb.sv

//--- Bender.yml
package:
  name: p4_router

sources:
  - include_dirs:
      - include
    files:
      - logic/router_pkg.sv
      - logic/ingress_decode.sv
      - logic/route_execute.sv
      - logic/egress_result.sv
      - logic/p4_router.sv
      - target: simulation
        files:
          - sim/p4_router_props.sv
          - sim/p4_router_tb.sv

//--- sim/p4_router_tb.sv
/* p4_router testbench: clock, reset, apb and stream stimulus,
   route table model, output beat checks */

`timescale 1ns/1ns
`include "router_params.svh"

module p4_router_tb;

    import router_pkg::*;

    localparam int TIMEOUT = 200;   // cycles per wait loop

    typedef struct packed {
        logic [7:0]  port;
        logic [7:0]  keep;
        logic        last;
        logic [63:0] data;
    } beat_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [7:0]  paddr = '0;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [31:0] pwdata = '0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [63:0] s_tdata = '0;
    logic [7:0]  s_tkeep = '0;
    logic        s_tlast = 1'b0;
    logic        s_tvalid = 1'b0;
    logic        s_tready;
    logic [7:0]  s_ing_port = '0;
    logic [63:0] m_tdata;
    logic [7:0]  m_tkeep;
    logic        m_tlast;
    logic        m_tvalid;
    logic        m_tready = 1'b1;
    rtl_port_e   m_egr_port;
    logic [31:0] drop_count;

    integer      seed = 75973;
    logic        bp_on = 1'b0;              // random m_tready phase
    beat_t       exp_q[$];                  // predicted output beats
    beat_t       exp_beat;
    int          exp_drops = 0;
    logic [7:0]  keys [5] = '{8'h11, 8'h22, 8'h55, 8'h77, 8'h33};

    // shadow of the route table and CTRL
    logic [7:0]  tb_key [`ROUTER_TABLE_DEPTH];
    logic [7:0]  tb_egr [`ROUTER_TABLE_DEPTH];
    logic [1:0]  tb_op  [`ROUTER_TABLE_DEPTH];
    logic [`ROUTER_TABLE_DEPTH-1:0] tb_vld = '0;
    route_op_e   tb_ctrl = ROUTE_CPU;

    p4_router p4_router_i (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        m_tready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // failure reporting

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_with_failure();
    endtask

    task automatic check_timeout(input int cnt, input string what);
        if (cnt > TIMEOUT) begin
            $display("timeout while waiting for %s", what);
            stop_with_failure();
        end
    endtask

    // bound checker failures stop the run at once
    always @(p4_router_i.props_i.fail_count) begin
        if (p4_router_i.props_i.fail_count != 0) begin
            $display("a bound assertion on p4_router failed");
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model, returns {forwarded, rtl egress index}

    function automatic logic [8:0] predict_route(input logic [7:0] ing, input logic [7:0] key);
        logic       hit;
        logic [1:0] op;
        logic [7:0] egr;
        hit = 1'b0;
        op  = tb_ctrl;          // miss takes the default opcode
        egr = 8'hFF;
        for (int i = 0; i < `ROUTER_TABLE_DEPTH; i++) begin
            if (!hit && tb_vld[i] && (tb_key[i] == key)) begin
                hit = 1'b1;
                op  = tb_op[i];
                egr = tb_egr[i];
            end
        end
        if (ingress_map(ing) == P4_UNMAPPED) op = ROUTE_DROP;
        if (op == ROUTE_CPU) egr = P4_CPU;
        else if (op != ROUTE_FWD) return 9'h000;
        if (egress_map(egr) == 8'hFF) return 9'h000;
        return {1'b1, egress_map(egr)};
    endfunction

    always @(posedge clk) begin
        if (!reset && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                $display("output beat arrived with no beat predicted");
                stop_with_failure();
            end else begin
                exp_beat = exp_q.pop_front();
                assert (m_tdata == exp_beat.data)
                    else report_mismatch("m_tdata", m_tdata, exp_beat.data);
                assert (m_tkeep == exp_beat.keep)
                    else report_mismatch("m_tkeep", m_tkeep, exp_beat.keep);
                assert (m_tlast == exp_beat.last)
                    else report_mismatch("m_tlast", m_tlast, exp_beat.last);
                assert (m_egr_port == exp_beat.port)
                    else report_mismatch("m_egr_port", m_egr_port, exp_beat.port);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // apb and stream drivers, entered and left just after a falling edge

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int cnt;
        psel    = 1'b1;         // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            check_timeout(cnt, "APB pready");
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        assert (!err) else report_mismatch("pslverr", err, 0);
        assert (rd == exp) else report_mismatch("prdata", rd, exp);
    endtask

    // DROPS register and the drop_count port agree with the model
    task automatic drops_check(input logic [31:0] exp);
        read_check(`ROUTER_REG_DROPS, exp);
        assert (drop_count == exp) else report_mismatch("drop_count", drop_count, exp);
    endtask

    task automatic error_check(input logic wr, input logic [7:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_access(wr, addr, 32'h0, rd, err);
        assert (err) else report_mismatch("pslverr", err, 1);
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            check_timeout(cnt, "output queue to empty");
        end
        repeat (4) @(negedge clk);      // dropped beats leave the 3 stages
    endtask

    task automatic program_entry(input int idx, input logic [7:0] key, input logic [7:0] egr,
                                 input route_op_e op, input logic vld);
        logic [31:0] rd;
        logic        err;
        drain();
        tb_key[idx] = key;
        tb_egr[idx] = egr;
        tb_op[idx]  = op;
        tb_vld[idx] = vld;
        apb_access(1'b1, `ROUTER_REG_ENTRY0 + 4 * idx, {vld, 13'b0, op, egr, key}, rd, err);
    endtask

    task automatic set_ctrl(input route_op_e op);
        logic [31:0] rd;
        logic        err;
        drain();
        tb_ctrl = op;
        apb_access(1'b1, `ROUTER_REG_CTRL, {30'b0, op}, rd, err);
    endtask

    task automatic send_packet(input logic [7:0] ing, input logic [7:0] key, input int nbeats);
        logic [8:0]  route;
        logic [63:0] data;
        logic [7:0]  keep;
        int          cnt;
        route = predict_route(ing, key);
        if (!route[8]) exp_drops++;
        for (int b = 0; b < nbeats; b++) begin
            data = {$random(seed), $random(seed)};
            if (b == 0) data[7:0] = key;                     // header beat carries key
            keep = (b == nbeats - 1) ? 8'h3F : 8'hFF;
            if (route[8]) exp_q.push_back({route[7:0], keep, b == nbeats - 1, data});
            s_tvalid   = 1'b1;
            s_tdata    = data;
            s_tkeep    = keep;
            s_tlast    = (b == nbeats - 1);
            s_ing_port = (b == 0) ? ing : 8'hEE;             // ignored after header
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                check_timeout(cnt, "s_tready");
            end while (!s_tready);
            @(negedge clk);
        end
        s_tvalid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        program_entry(0, 8'h11, P4_ECG2, ROUTE_FWD, 1'b1);
        program_entry(1, 8'h22, P4_OISL0, ROUTE_FWD, 1'b1);
        program_entry(2, 8'h33, P4_ECP1, ROUTE_DROP, 1'b1);
        program_entry(3, 8'h44, 8'h99, ROUTE_FWD, 1'b1);     // egress id with no rtl port
        program_entry(4, 8'h11, P4_HDR1, ROUTE_FWD, 1'b1);   // shadowed by entry 0
        program_entry(5, 8'h55, P4_ECP0, ROUTE_CPU, 1'b1);
        for (int i = 0; i < 6; i++) begin
            read_check(`ROUTER_REG_ENTRY0 + 4 * i, {tb_vld[i], 13'b0, tb_op[i], tb_egr[i],
                       tb_key[i]});
        end
        read_check(`ROUTER_REG_CTRL, ROUTE_CPU);

        for (int p = 0; p <= 10; p++) begin                  // every mapped ingress port
            send_packet(p, (p % 2) ? 8'h22 : 8'h11, 1 + ($random(seed) & 3));
        end

        send_packet(3, 8'h77, 2);                            // miss, punted to cpu
        set_ctrl(ROUTE_DROP);
        send_packet(5, 8'h77, 3);                            // miss, dropped
        set_ctrl(ROUTE_CPU);

        send_packet(2, 8'h33, 2);
        send_packet(11, 8'h11, 1);
        send_packet(8'hC8, 8'h22, 2);
        send_packet(7, 8'h44, 4);
        send_packet(4, 8'h55, 2);
        drain();
        drops_check(exp_drops);
        error_check(1'b0, 8'h08);
        drops_check(exp_drops);
        begin : clear_drops
            logic [31:0] rd;
            logic        err;
            apb_access(1'b1, `ROUTER_REG_DROPS, 32'hDEAD_BEEF, rd, err);
        end
        exp_drops = 0;
        drops_check(32'h0);

        bp_on = 1'b1;
        for (int n = 0; n < 24; n++) begin
            send_packet($unsigned($random(seed)) % 11, keys[$unsigned($random(seed)) % 5],
                        1 + ($random(seed) & 3));
        end
        drain();
        bp_on = 1'b0;
        drops_check(exp_drops);

        error_check(1'b1, 8'h60);                            // past the last entry
        error_check(1'b0, 8'h41);                            // unaligned entry address

        if (p4_router_i.props_i.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d bound assertion failures", p4_router_i.props_i.fail_count);
            stop_with_failure();
        end
    end

endmodule

//--- sim/p4_router_props.sv
/* bound checks on p4_router: output reset value, stall hold,
   apb ready and error response */

`timescale 1ns/1ns
`include "router_params.svh"

module p4_router_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      psel,
    input logic                      penable,
    input logic                      pready,
    input logic                      pslverr,
    input logic [`ROUTER_DATA_W-1:0] m_tdata,
    input logic [`ROUTER_KEEP_W-1:0] m_tkeep,
    input logic                      m_tlast,
    input logic                      m_tvalid,
    input logic                      m_tready,
    input logic [7:0]                m_egr_port
);

    int fail_count = 0;     // read by the testbench

    ////////////////////////////////////////////////////////////
    // stream output

    assert property (@(posedge clk) reset |=> !m_tvalid)
        else begin
            $error("m_tvalid high after a reset cycle");
            fail_count++;
        end

    // stalled beat keeps valid, payload and port
    assert property (@(posedge clk) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_egr_port}))
        else begin
            $error("output beat changed while stalled");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // apb

    assert property (@(posedge clk) disable iff (reset) psel && penable |-> pready)
        else begin
            $error("pready low in access phase");
            fail_count++;
        end

    assert property (@(posedge clk) pslverr |-> psel && penable)
        else begin
            $error("pslverr outside access phase");
            fail_count++;
        end

endmodule

bind p4_router p4_router_props props_i (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_egr_port (m_egr_port)
);

//--- logic/p4_router.sv
/* p4 router top: decode, execute and result
   stages on one clock */

`timescale 1ns/1ns
`include "router_params.svh"

module p4_router (
    input  logic                        clk,
    input  logic                        reset,
    // apb control
    input  logic [`ROUTER_APB_AW-1:0]   paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`ROUTER_APB_DW-1:0]   pwdata,
    output logic [`ROUTER_APB_DW-1:0]   prdata,
    output logic                        pready,
    output logic                        pslverr,
    // ingress stream
    input  logic [`ROUTER_DATA_W-1:0]   s_tdata,
    input  logic [`ROUTER_KEEP_W-1:0]   s_tkeep,
    input  logic                        s_tlast,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic [7:0]                  s_ing_port,
    // egress stream
    output logic [`ROUTER_DATA_W-1:0]   m_tdata,
    output logic [`ROUTER_KEEP_W-1:0]   m_tkeep,
    output logic                        m_tlast,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output router_pkg::rtl_port_e       m_egr_port,
    output logic [`ROUTER_DROP_W-1:0]   drop_count
);

    import router_pkg::*;

    ////////////////////////////////////////////////////////////
    // stage links

    logic [`ROUTER_DATA_W-1:0] dec_tdata;   // decode to execute
    logic [`ROUTER_KEEP_W-1:0] dec_tkeep;
    logic                      dec_tlast;
    logic                      dec_tvalid;
    logic                      dec_tready;
    logic                      dec_sop;
    logic [7:0]                dec_key;
    p4_port_e                  dec_ing_id;

    logic [`ROUTER_DATA_W-1:0] exe_tdata;   // execute to result
    logic [`ROUTER_KEEP_W-1:0] exe_tkeep;
    logic                      exe_tlast;
    logic                      exe_tvalid;
    logic                      exe_tready;
    route_op_e                 exe_op;
    p4_port_e                  exe_egr_id;
    logic                      drop_clear;

    ingress_decode ingress_decode_i (
        .clk        (clk),
        .reset      (reset),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tlast    (s_tlast),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_ing_port (s_ing_port),
        .dec_tdata  (dec_tdata),
        .dec_tkeep  (dec_tkeep),
        .dec_tlast  (dec_tlast),
        .dec_tvalid (dec_tvalid),
        .dec_tready (dec_tready),
        .dec_sop    (dec_sop),
        .dec_key    (dec_key),
        .dec_ing_id (dec_ing_id)
    );

    route_execute route_execute_i (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .dec_tdata  (dec_tdata),
        .dec_tkeep  (dec_tkeep),
        .dec_tlast  (dec_tlast),
        .dec_tvalid (dec_tvalid),
        .dec_tready (dec_tready),
        .dec_sop    (dec_sop),
        .dec_key    (dec_key),
        .dec_ing_id (dec_ing_id),
        .exe_tdata  (exe_tdata),
        .exe_tkeep  (exe_tkeep),
        .exe_tlast  (exe_tlast),
        .exe_tvalid (exe_tvalid),
        .exe_tready (exe_tready),
        .exe_op     (exe_op),
        .exe_egr_id (exe_egr_id),
        .drop_count (drop_count),   // read back through DROPS
        .drop_clear (drop_clear)
    );

    egress_result egress_result_i (
        .clk        (clk),
        .reset      (reset),
        .exe_tdata  (exe_tdata),
        .exe_tkeep  (exe_tkeep),
        .exe_tlast  (exe_tlast),
        .exe_tvalid (exe_tvalid),
        .exe_tready (exe_tready),
        .exe_op     (exe_op),
        .exe_egr_id (exe_egr_id),
        .drop_clear (drop_clear),
        .m_tdata    (m_tdata),
        .m_tkeep    (m_tkeep),
        .m_tlast    (m_tlast),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_egr_port (m_egr_port),
        .drop_count (drop_count)
    );

endmodule

//--- logic/egress_result.sv
/* egress result: program to rtl port mapping, drop and punt
   gating, drop counter and output register stage */

`timescale 1ns/1ns
`include "router_params.svh"

module egress_result (
    input  logic                        clk,
    input  logic                        reset,
    // from execute
    input  logic [`ROUTER_DATA_W-1:0]   exe_tdata,
    input  logic [`ROUTER_KEEP_W-1:0]   exe_tkeep,
    input  logic                        exe_tlast,
    input  logic                        exe_tvalid,
    output logic                        exe_tready,
    input  router_pkg::route_op_e       exe_op,
    input  router_pkg::p4_port_e        exe_egr_id,
    input  logic                        drop_clear,   // one cycle, from DROPS write
    // egress stream
    output logic [`ROUTER_DATA_W-1:0]   m_tdata,
    output logic [`ROUTER_KEEP_W-1:0]   m_tkeep,
    output logic                        m_tlast,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output router_pkg::rtl_port_e       m_egr_port,   // valid with every beat
    output logic [`ROUTER_DROP_W-1:0]   drop_count
);

    import router_pkg::*;

    ////////////////////////////////////////////////////////////
    // egress mapping and drop decision

    logic [7:0] egr_idx;     // rtl index, 0xFF when unmapped
    logic       drop_beat;   // beat belongs to a dropped packet
    logic       exe_fire;

    assign egr_idx   = egress_map(exe_egr_id);
    assign drop_beat = (exe_op == ROUTE_DROP) || (egr_idx == 8'hFF);

    assign exe_tready = m_tready || !m_tvalid;
    assign exe_fire   = exe_tvalid && exe_tready;

    ////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (reset) begin
            m_tvalid <= 1'b0;
        end else if (exe_tready) begin
            m_tvalid <= exe_tvalid && !drop_beat;   // dropped beats leave a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (exe_fire && !drop_beat) begin
            m_tdata    <= exe_tdata;
            m_tkeep    <= exe_tkeep;
            m_tlast    <= exe_tlast;
            m_egr_port <= rtl_port_e'(egr_idx);
        end
    end

    ////////////////////////////////////////////////////////////
    // drop counter

    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (drop_clear) begin
            drop_count <= '0;                       // clear beats a same cycle count
        end else if (exe_fire && drop_beat && exe_tlast && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;        // once per packet, saturating
        end
    end

endmodule

//--- logic/route_execute.sv
/* route execute: apb register file, route table,
   key lookup and second register stage */

`timescale 1ns/1ns
`include "router_params.svh"

module route_execute (
    input  logic                        clk,
    input  logic                        reset,
    // apb target
    input  logic [`ROUTER_APB_AW-1:0]   paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`ROUTER_APB_DW-1:0]   pwdata,
    output logic [`ROUTER_APB_DW-1:0]   prdata,
    output logic                        pready,
    output logic                        pslverr,
    // from decode
    input  logic [`ROUTER_DATA_W-1:0]   dec_tdata,
    input  logic [`ROUTER_KEEP_W-1:0]   dec_tkeep,
    input  logic                        dec_tlast,
    input  logic                        dec_tvalid,
    output logic                        dec_tready,
    input  logic                        dec_sop,
    input  logic [7:0]                  dec_key,
    input  router_pkg::p4_port_e        dec_ing_id,
    // towards result
    output logic [`ROUTER_DATA_W-1:0]   exe_tdata,
    output logic [`ROUTER_KEEP_W-1:0]   exe_tkeep,
    output logic                        exe_tlast,
    output logic                        exe_tvalid,
    input  logic                        exe_tready,
    output router_pkg::route_op_e       exe_op,       // held for the packet
    output router_pkg::p4_port_e        exe_egr_id,   // held for the packet
    // drop counter lives in result
    input  logic [`ROUTER_DROP_W-1:0]   drop_count,
    output logic                        drop_clear
);

    import router_pkg::*;

    localparam int DEPTH = `ROUTER_TABLE_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    ////////////////////////////////////////////////////////////
    // apb decode

    logic                      apb_acc;     // access phase
    logic                      apb_wr;
    logic                      ctrl_hit;
    logic                      drops_hit;
    logic                      entry_hit;
    logic [`ROUTER_APB_AW-1:0] entry_off;
    logic [IDX_W-1:0]          entry_idx;

    assign apb_acc   = psel && penable;
    assign apb_wr    = apb_acc && pwrite;
    assign ctrl_hit  = (paddr == `ROUTER_REG_CTRL);
    assign drops_hit = (paddr == `ROUTER_REG_DROPS);
    assign entry_off = paddr - `ROUTER_REG_ENTRY0;
    assign entry_hit = (paddr >= `ROUTER_REG_ENTRY0) && (entry_off < 4 * DEPTH)
                       && (paddr[1:0] == 2'b00);   // word aligned only
    assign entry_idx = entry_off[IDX_W+1:2];

    assign pready  = apb_acc;                                          // zero wait states
    assign pslverr = apb_acc && !(ctrl_hit || drops_hit || entry_hit); // hole in the map

    ////////////////////////////////////////////////////////////
    // register file and route table

    route_op_e        ctrl_op;              // default opcode on a miss
    logic [DEPTH-1:0] entry_vld;
    logic [7:0]       entry_key [DEPTH];
    logic [7:0]       entry_egr [DEPTH];    // program egress id
    logic [1:0]       entry_op  [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_op    <= ROUTE_CPU;
            entry_vld  <= '0;
            drop_clear <= 1'b0;
        end else begin
            drop_clear <= apb_wr && drops_hit;   // any value clears
            if (apb_wr && ctrl_hit) begin
                ctrl_op <= route_op_e'(pwdata[1:0]);
            end
            if (apb_wr && entry_hit) begin
                entry_vld[entry_idx] <= pwdata[31];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (apb_wr && entry_hit) begin
            entry_key[entry_idx] <= pwdata[7:0];
            entry_egr[entry_idx] <= pwdata[15:8];
            entry_op[entry_idx]  <= pwdata[17:16];
        end
    end

    always_comb begin
        prdata = '0;
        if (apb_acc && !pwrite) begin
            if (ctrl_hit) begin
                prdata[1:0] = ctrl_op;
            end else if (drops_hit) begin
                prdata = drop_count;
            end else if (entry_hit) begin
                prdata = {entry_vld[entry_idx], 13'b0, entry_op[entry_idx],
                          entry_egr[entry_idx], entry_key[entry_idx]};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup and route resolution

    logic      hit;
    route_op_e hit_op;
    p4_port_e  hit_egr;
    route_op_e res_op;
    p4_port_e  res_egr;

    always_comb begin
        hit     = 1'b0;
        hit_op  = ROUTE_DROP;
        hit_egr = P4_UNMAPPED;
        for (int i = DEPTH - 1; i >= 0; i--) begin   // walk down, lowest index wins
            if (entry_vld[i] && (entry_key[i] == dec_key)) begin
                hit     = 1'b1;
                hit_op  = route_op_e'(entry_op[i]);
                hit_egr = p4_port_e'(entry_egr[i]);
            end
        end
    end

    always_comb begin
        res_op = hit ? hit_op : ctrl_op;
        // unmapped ingress and the spare opcode both drop
        if ((dec_ing_id == P4_UNMAPPED) || !(res_op inside {ROUTE_FWD, ROUTE_CPU})) begin
            res_op = ROUTE_DROP;
        end
        res_egr = (res_op == ROUTE_CPU) ? P4_CPU : hit_egr;   // fwd miss stays unmapped
    end

    ////////////////////////////////////////////////////////////
    // register stage

    logic dec_fire;

    assign dec_tready = exe_tready || !exe_tvalid;
    assign dec_fire   = dec_tvalid && dec_tready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_tvalid <= 1'b0;
        end else if (dec_tready) begin
            exe_tvalid <= dec_tvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_fire) begin
            exe_tdata <= dec_tdata;
            exe_tkeep <= dec_tkeep;
            exe_tlast <= dec_tlast;
            if (dec_sop) begin   // route decided once per packet
                exe_op     <= res_op;
                exe_egr_id <= res_egr;
            end
        end
    end

endmodule

//--- logic/ingress_decode.sv
/* ingress decode: rtl to program port mapping,
   header key extraction, first register stage */

`timescale 1ns/1ns
`include "router_params.svh"

module ingress_decode (
    input  logic                        clk,
    input  logic                        reset,
    // ingress stream
    input  logic [`ROUTER_DATA_W-1:0]   s_tdata,
    input  logic [`ROUTER_KEEP_W-1:0]   s_tkeep,
    input  logic                        s_tlast,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic [7:0]                  s_ing_port,   // sampled on header beat
    // towards execute
    output logic [`ROUTER_DATA_W-1:0]   dec_tdata,
    output logic [`ROUTER_KEEP_W-1:0]   dec_tkeep,
    output logic                        dec_tlast,
    output logic                        dec_tvalid,
    input  logic                        dec_tready,
    output logic                        dec_sop,      // header beat flag
    output logic [7:0]                  dec_key,      // held for the packet
    output router_pkg::p4_port_e        dec_ing_id    // held for the packet
);

    import router_pkg::*;

    ////////////////////////////////////////////////////////////
    // packet position

    logic in_pkt;   // past the header beat
    logic s_fire;   // beat accepted this cycle
    logic sop;      // current input beat is a header

    assign s_tready = dec_tready || !dec_tvalid;   // pass ready or fill empty slot
    assign s_fire   = s_tvalid && s_tready;
    assign sop      = !in_pkt;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (s_fire) begin
            in_pkt <= !s_tlast;     // back to header after last beat
        end
    end

    ////////////////////////////////////////////////////////////
    // register stage

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_tvalid <= 1'b0;
        end else if (s_tready) begin
            dec_tvalid <= s_tvalid;   // load or drain
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (s_fire) begin
            dec_tdata <= s_tdata;
            dec_tkeep <= s_tkeep;
            dec_tlast <= s_tlast;
            dec_sop   <= sop;
            if (sop) begin
                dec_key    <= s_tdata[7:0];             // destination key in low byte
                dec_ing_id <= ingress_map(s_ing_port);  // unmapped gives 0xFF
            end
        end
    end

endmodule

//--- logic/router_pkg.sv
/* router package: port id enums, route opcode
   and the rtl/program port map functions */

package router_pkg;

    // rtl port indices, as wired in the fabric
    typedef enum logic [7:0] {
        RTL_CPU   = 8'd0,
        RTL_OISL0 = 8'd1,
        RTL_OISL1 = 8'd2,
        RTL_ECP0  = 8'd3,
        RTL_ECP1  = 8'd4,
        RTL_HDR0  = 8'd5,
        RTL_HDR1  = 8'd6,
        RTL_ECG0  = 8'd7,
        RTL_ECG1  = 8'd8,
        RTL_ECG2  = 8'd9,
        RTL_ECG3  = 8'd10
    } rtl_port_e;

    // port ids seen by the forwarding program
    typedef enum logic [7:0] {
        P4_CPU      = 8'd0,
        P4_OISL0    = 8'd20,
        P4_OISL1    = 8'd21,
        P4_ECP0     = 8'd40,
        P4_ECP1     = 8'd41,
        P4_HDR0     = 8'd60,
        P4_HDR1     = 8'd61,
        P4_ECG0     = 8'd80,
        P4_ECG1     = 8'd81,
        P4_ECG2     = 8'd82,
        P4_ECG3     = 8'd83,
        P4_UNMAPPED = 8'hFF     // no such port
    } p4_port_e;

    typedef enum logic [1:0] {
        ROUTE_FWD  = 2'd0,      // to the table egress id
        ROUTE_DROP = 2'd1,      // swallow the packet
        ROUTE_CPU  = 2'd2       // punt to the cpu port
    } route_op_e;

    function automatic p4_port_e ingress_map(input logic [7:0] rtl_idx);
        case (rtl_idx)
            RTL_CPU   : return P4_CPU;
            RTL_OISL0 : return P4_OISL0;
            RTL_OISL1 : return P4_OISL1;
            RTL_ECP0  : return P4_ECP0;
            RTL_ECP1  : return P4_ECP1;
            RTL_HDR0  : return P4_HDR0;
            RTL_HDR1  : return P4_HDR1;
            RTL_ECG0  : return P4_ECG0;
            RTL_ECG1  : return P4_ECG1;
            RTL_ECG2  : return P4_ECG2;
            RTL_ECG3  : return P4_ECG3;
            default   : return P4_UNMAPPED;
        endcase
    endfunction

    // 8'hFF back means the program id has no rtl port
    function automatic logic [7:0] egress_map(input logic [7:0] p4_id);
        case (p4_id)
            P4_CPU   : return RTL_CPU;
            P4_OISL0 : return RTL_OISL0;
            P4_OISL1 : return RTL_OISL1;
            P4_ECP0  : return RTL_ECP0;
            P4_ECP1  : return RTL_ECP1;
            P4_HDR0  : return RTL_HDR0;
            P4_HDR1  : return RTL_HDR1;
            P4_ECG0  : return RTL_ECG0;
            P4_ECG1  : return RTL_ECG1;
            P4_ECG2  : return RTL_ECG2;
            P4_ECG3  : return RTL_ECG3;
            default  : return 8'hFF;
        endcase
    endfunction

endpackage

//--- include/router_params.svh
/* router widths, route table depth
   and APB register offsets */

`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

////////////////////////////////////////////////////////////
// stream and bus widths

`define ROUTER_DATA_W       64      // stream data, one word
`define ROUTER_KEEP_W       8       // byte enables
`define ROUTER_APB_AW       8       // apb address bits used
`define ROUTER_APB_DW       32      // apb data
`define ROUTER_DROP_W       32      // drop counter, same as apb data

////////////////////////////////////////////////////////////
// route table and register map

`define ROUTER_TABLE_DEPTH  8       // entries in the route table
`define ROUTER_REG_CTRL     8'h00   // default opcode on a miss
`define ROUTER_REG_DROPS    8'h04   // dropped packet count
`define ROUTER_REG_ENTRY0   8'h40   // entry i at +4*i

`endif
